/* rtl/brisc_pkg.sv */
package brisc_pkg;

  // data word width of the core
  localparam int unsigned XLEN = 32;

  // word address width
  localparam int unsigned ADDR_WIDTH = 32;

endpackage

/* rtl/cache_pkg.sv */
package cache_pkg;

  // direct-mapped geometry, one word per line
  localparam int unsigned SET_BITS = 2;
  localparam int unsigned CACHE_LINES = 2 ** SET_BITS;

  // everything above the set index is tag
  localparam int unsigned TAG_WIDTH = brisc_pkg::ADDR_WIDTH - SET_BITS;

  // controller states
  // lookup is the single cycle where the array is read
  // the two wait states hold until the memory ack
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_LOOKUP     = 3'd1,
    ST_MISS_WAIT  = 3'd2,
    ST_WRITE_WAIT = 3'd3,
    ST_RESPOND    = 3'd4
  } ctrl_state_e;

endpackage

/* rtl/cache_line.sv */
`timescale 1ns/1ps

module cache_line (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            write,
  input  logic [cache_pkg::TAG_WIDTH-1:0] tag_in,
  input  logic [brisc_pkg::XLEN-1:0]      data_in,
  output logic                            valid_out,
  output logic [cache_pkg::TAG_WIDTH-1:0] tag_out,
  output logic [brisc_pkg::XLEN-1:0]      data_out
);

  logic                            valid_q;
  logic [cache_pkg::TAG_WIDTH-1:0] tag_q;
  logic [brisc_pkg::XLEN-1:0]      data_q;

  // valid bit, cleared only by reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (write) begin
      valid_q <= 1'b1;
    end
  end

  // tag and data storage
  always_ff @(posedge clk) begin
    if (write) begin
      tag_q  <= tag_in;
      data_q <= data_in;
    end
  end

  assign valid_out = valid_q;
  assign tag_out   = tag_q;
  assign data_out  = data_q;

endmodule

/* rtl/cache_array.sv */
`timescale 1ns/1ps

module cache_array (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             line_write,
  input  logic [brisc_pkg::ADDR_WIDTH-1:0] line_addr,
  input  logic [brisc_pkg::XLEN-1:0]       line_wdata,
  output logic                             lookup_hit,
  output logic [brisc_pkg::XLEN-1:0]       lookup_data
);

  logic [cache_pkg::SET_BITS-1:0]  set;
  logic [cache_pkg::TAG_WIDTH-1:0] tag;

  // per-line signals
  logic                            write_en[cache_pkg::CACHE_LINES];
  logic                            valid_from_lines[cache_pkg::CACHE_LINES];
  logic [cache_pkg::TAG_WIDTH-1:0] tag_from_lines[cache_pkg::CACHE_LINES];
  logic [brisc_pkg::XLEN-1:0]      data_from_lines[cache_pkg::CACHE_LINES];

  // low bits pick the set, the rest is tag
  assign set = line_addr[cache_pkg::SET_BITS-1:0];
  assign tag = line_addr[brisc_pkg::ADDR_WIDTH-1:cache_pkg::SET_BITS];

  genvar i;
  generate
    for (i = 0; i < cache_pkg::CACHE_LINES; i++) begin : g_cache_line
      // write goes to the selected line only
      assign write_en[i] = line_write && (int'(set) == i);

      cache_line u_line (
        .clk       (clk),
        .arst_n    (arst_n),
        .write     (write_en[i]),
        .tag_in    (tag),
        .data_in   (line_wdata),
        .valid_out (valid_from_lines[i]),
        .tag_out   (tag_from_lines[i]),
        .data_out  (data_from_lines[i])
      );
    end
  endgenerate

  // hit needs a valid line with a matching tag
  assign lookup_hit  = valid_from_lines[set] && (tag_from_lines[set] == tag);
  assign lookup_data = data_from_lines[set];

endmodule

/* rtl/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                             clk,
  input  logic                             arst_n,
  // core side
  input  logic                             req_valid,
  input  logic                             req_write,
  input  logic [brisc_pkg::ADDR_WIDTH-1:0] req_addr,
  input  logic [brisc_pkg::XLEN-1:0]       req_wdata,
  output logic                             busy,
  output logic                             resp_valid,
  output logic                             resp_hit,
  output logic [brisc_pkg::XLEN-1:0]       resp_rdata,
  // memory side
  output logic                             mem_rd,
  output logic                             mem_wr,
  output logic [brisc_pkg::ADDR_WIDTH-1:0] mem_addr,
  output logic [brisc_pkg::XLEN-1:0]       mem_wdata,
  input  logic                             mem_ack,
  input  logic [brisc_pkg::XLEN-1:0]       mem_rdata,
  // array side
  input  logic                             lookup_hit,
  input  logic [brisc_pkg::XLEN-1:0]       lookup_data,
  output logic                             line_write,
  output logic [brisc_pkg::ADDR_WIDTH-1:0] line_addr,
  output logic [brisc_pkg::XLEN-1:0]       line_wdata
);

  cache_pkg::ctrl_state_e state;
  cache_pkg::ctrl_state_e state_next;

  // latched request
  logic                             write_q;
  logic [brisc_pkg::ADDR_WIDTH-1:0] addr_q;
  logic [brisc_pkg::XLEN-1:0]       wdata_q;

  logic accept;
  logic in_lookup;
  logic fill;

  assign busy      = (state != cache_pkg::ST_IDLE);
  assign accept    = req_valid && !busy;
  assign in_lookup = (state == cache_pkg::ST_LOOKUP);
  assign fill      = (state == cache_pkg::ST_MISS_WAIT) && mem_ack;

  always_comb begin
    state_next = state;
    case (state)
      cache_pkg::ST_IDLE: begin
        if (req_valid) begin
          state_next = cache_pkg::ST_LOOKUP;
        end
      end
      cache_pkg::ST_LOOKUP: begin
        if (write_q) begin
          state_next = cache_pkg::ST_WRITE_WAIT;
        end else if (lookup_hit) begin
          state_next = cache_pkg::ST_RESPOND;
        end else begin
          state_next = cache_pkg::ST_MISS_WAIT;
        end
      end
      cache_pkg::ST_MISS_WAIT, cache_pkg::ST_WRITE_WAIT: begin
        if (mem_ack) begin
          state_next = cache_pkg::ST_RESPOND;
        end
      end
      cache_pkg::ST_RESPOND: begin
        state_next = cache_pkg::ST_IDLE;
      end
      default: begin
        state_next = cache_pkg::ST_IDLE;
      end
    endcase
  end

  // state and memory strobes
  // strobes rise the cycle after lookup and last one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= cache_pkg::ST_IDLE;
      mem_rd <= 1'b0;
      mem_wr <= 1'b0;
    end else begin
      state  <= state_next;
      mem_rd <= in_lookup && !write_q && !lookup_hit;
      mem_wr <= in_lookup && write_q;
    end
  end

  // request and response payload
  always_ff @(posedge clk) begin
    if (accept) begin
      write_q <= req_write;
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
    if (in_lookup) begin
      resp_hit   <= lookup_hit;
      // a write answers with the word it stored
      resp_rdata <= write_q ? wdata_q : lookup_data;
    end else if (fill) begin
      resp_rdata <= mem_rdata;
    end
  end

  assign resp_valid = (state == cache_pkg::ST_RESPOND);

  // one address register serves both array and memory
  assign mem_addr  = addr_q;
  assign mem_wdata = wdata_q;
  assign line_addr = addr_q;

  // fill on ack, write-through line update with the mem_wr pulse
  assign line_write = fill || ((state == cache_pkg::ST_WRITE_WAIT) && mem_wr);
  assign line_wdata = (state == cache_pkg::ST_MISS_WAIT) ? mem_rdata : wdata_q;

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
  input  logic                             clk,
  input  logic                             arst_n,
  // core side
  input  logic                             req_valid,
  input  logic                             req_write,
  input  logic [brisc_pkg::ADDR_WIDTH-1:0] req_addr,
  input  logic [brisc_pkg::XLEN-1:0]       req_wdata,
  output logic                             busy,
  output logic                             resp_valid,
  output logic                             resp_hit,
  output logic [brisc_pkg::XLEN-1:0]       resp_rdata,
  // memory side
  output logic                             mem_rd,
  output logic                             mem_wr,
  output logic [brisc_pkg::ADDR_WIDTH-1:0] mem_addr,
  output logic [brisc_pkg::XLEN-1:0]       mem_wdata,
  input  logic                             mem_ack,
  input  logic [brisc_pkg::XLEN-1:0]       mem_rdata
);

  // controller to array
  logic                             line_write;
  logic [brisc_pkg::ADDR_WIDTH-1:0] line_addr;
  logic [brisc_pkg::XLEN-1:0]       line_wdata;
  logic                             lookup_hit;
  logic [brisc_pkg::XLEN-1:0]       lookup_data;

  cache_ctrl u_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .busy        (busy),
    .resp_valid  (resp_valid),
    .resp_hit    (resp_hit),
    .resp_rdata  (resp_rdata),
    .mem_rd      (mem_rd),
    .mem_wr      (mem_wr),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .lookup_hit  (lookup_hit),
    .lookup_data (lookup_data),
    .line_write  (line_write),
    .line_addr   (line_addr),
    .line_wdata  (line_wdata)
  );

  cache_array u_array (
    .clk         (clk),
    .arst_n      (arst_n),
    .line_write  (line_write),
    .line_addr   (line_addr),
    .line_wdata  (line_wdata),
    .lookup_hit  (lookup_hit),
    .lookup_data (lookup_data)
  );

endmodule

/* bench/dcache_assert.sv */
`timescale 1ns/1ps

module dcache_assert (
  input logic                             clk,
  input logic                             arst_n,
  input logic                             busy,
  input logic                             resp_valid,
  input logic                             mem_rd,
  input logic                             mem_wr,
  input logic                             mem_ack,
  input logic [brisc_pkg::ADDR_WIDTH-1:0] mem_addr
);

  // open from the cycle after a strobe through its ack
  logic access_open;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      access_open <= 1'b0;
    end else if (mem_rd || mem_wr) begin
      access_open <= 1'b1;
    end else if (mem_ack) begin
      access_open <= 1'b0;
    end
  end

  // only one kind of memory access at a time
  a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(mem_rd && mem_wr))
    else $error("mem_rd and mem_wr high together");

  a_resp_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
    resp_valid |-> busy)
    else $error("resp_valid without busy");

  // strobes are single-cycle pulses
  a_rd_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rd |=> !mem_rd)
    else $error("mem_rd longer than one cycle");

  a_wr_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    mem_wr |=> !mem_wr)
    else $error("mem_wr longer than one cycle");

  // address held from the strobe through the ack
  a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
    access_open |-> $stable(mem_addr))
    else $error("mem_addr changed before mem_ack");

endmodule

bind cache_ctrl dcache_assert u_assert (
  .clk        (clk),
  .arst_n     (arst_n),
  .busy       (busy),
  .resp_valid (resp_valid),
  .mem_rd     (mem_rd),
  .mem_wr     (mem_wr),
  .mem_ack    (mem_ack),
  .mem_addr   (mem_addr)
);

/* bench/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

  localparam int NUM_REQS       = 200;
  localparam int NUM_ADDRS      = 12;
  localparam int TIMEOUT_CYCLES = NUM_REQS * 12 + 100;

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        hit;
    logic [31:0] rdata;
  } exp_t;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        req_valid;
  logic        req_write;
  logic [31:0] req_addr;
  logic [31:0] req_wdata;
  logic        busy;
  logic        resp_valid;
  logic        resp_hit;
  logic [31:0] resp_rdata;
  logic        mem_rd;
  logic        mem_wr;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_ack;
  logic [31:0] mem_rdata;

  // reference model state, tag and valid per set plus memory contents
  logic        ref_valid[cache_pkg::CACHE_LINES];
  logic [31:0] ref_tag[cache_pkg::CACHE_LINES];
  logic [31:0] ref_mem[logic [31:0]];

  // memory model storage, unwritten words read back as their address
  logic [31:0] mem_words[logic [31:0]];

  logic [31:0] addr_pool[NUM_ADDRS];
  logic [31:0] stim_state = 32'hc6ca_d2b8;
  logic [31:0] mem_state  = 32'hc6ca_d2b8;
  exp_t        exp_q[$];
  exp_t        cur;
  int          resp_count    = 0;
  int          mem_req_count = 0;
  int          cycle_count   = 0;
  logic        ack_prev      = 1'b0;
  logic        busy_exp      = 1'b0;

  dcache_top u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valid  (req_valid),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_rdata (resp_rdata),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected response of one request, updates the model as the cache would
  function automatic void predict_response(input logic write, input logic [31:0] addr,
      input logic [31:0] wdata, output logic hit, output logic [31:0] rdata);
    int unsigned set;
    logic [31:0] tag;
    set = addr % cache_pkg::CACHE_LINES;
    tag = addr >> cache_pkg::SET_BITS;
    hit = ref_valid[set] && (ref_tag[set] == tag);
    if (write) begin
      ref_mem[addr] = wdata;
      rdata = wdata;
    end else begin
      rdata = ref_mem.exists(addr) ? ref_mem[addr] : addr;
    end
    // read miss fills, write allocates, so the line always ends up holding addr
    ref_valid[set] = 1'b1;
    ref_tag[set]   = tag;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("error: %s = 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  task automatic issue_request(input logic write, input logic [31:0] addr,
      input logic [31:0] wdata, input logic poke_busy);
    exp_t e;
    e.write = write;
    e.addr  = addr;
    e.wdata = wdata;
    predict_response(write, addr, wdata, e.hit, e.rdata);
    exp_q.push_back(e);
    req_valid <= 1'b1;
    req_write <= write;
    req_addr  <= addr;
    req_wdata <= wdata;
    @(posedge clk);
    if (poke_busy) begin
      // this strobe lands while busy is high and must be dropped
      req_write <= ~write;
      req_addr  <= ~addr;
      req_wdata <= ~wdata;
      @(posedge clk);
    end
    req_valid <= 1'b0;
    do begin
      @(posedge clk);
    end while (busy);
  endtask

  initial begin : stimulus
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] ctrl;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    arst_n    = 1'b0;
    for (int s = 0; s < cache_pkg::CACHE_LINES; s++) begin
      ref_valid[s] = 1'b0;
      ref_tag[s]   = '0;
    end
    // three addresses per set so lines get evicted
    for (int i = 0; i < NUM_ADDRS; i++) begin
      addr_pool[i] = ((32'h0040_0000 + 32'(i / cache_pkg::CACHE_LINES) * 32'h111)
                      << cache_pkg::SET_BITS) | 32'(i % cache_pkg::CACHE_LINES);
    end
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (int n = 0; n < NUM_REQS; n++) begin
      stim_state = lcg_step(stim_state);
      addr       = addr_pool[stim_state[31:16] % 16'd12];
      stim_state = lcg_step(stim_state);
      wdata      = stim_state;
      stim_state = lcg_step(stim_state);
      ctrl       = stim_state;
      issue_request(ctrl[31:29] < 3'd3, addr, wdata, ctrl[28:27] == 2'b00);
    end
    check_value("resp_count", resp_count, NUM_REQS);
    $display("Finished with no errors");
    $finish;
  end

  // memory model with 1 to 4 cycles of latency
  initial begin : memory_model
    int          wait_cycles;
    logic        acc_write;
    logic [31:0] acc_addr;
    logic [31:0] acc_wdata;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever begin
      @(posedge clk);
      if (mem_rd || mem_wr) begin
        // capture the access while its strobe is still visible
        acc_write   = mem_wr;
        acc_addr    = mem_addr;
        acc_wdata   = mem_wdata;
        mem_state   = lcg_step(mem_state);
        wait_cycles = 1 + int'(mem_state[31:30]);
        repeat (wait_cycles - 1) @(posedge clk);
        if (acc_write) begin
          mem_words[acc_addr] = acc_wdata;
        end else begin
          mem_rdata <= mem_words.exists(acc_addr) ? mem_words[acc_addr] : acc_addr;
        end
        mem_ack <= 1'b1;
        @(posedge clk);
        mem_ack <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (arst_n) begin
      check_value("busy", busy, busy_exp);
      if (mem_rd || mem_wr) begin
        if (exp_q.size() == 0) begin
          abort_run("memory request seen with no request in flight");
        end
        cur = exp_q[0];
        check_value("mem_rd", mem_rd, !cur.write && !cur.hit);
        check_value("mem_wr", mem_wr, cur.write);
        check_value("mem_addr", mem_addr, cur.addr);
        if (mem_wr) begin
          check_value("mem_wdata", mem_wdata, cur.wdata);
        end
        mem_req_count++;
      end
      if (resp_valid) begin
        if (exp_q.size() == 0) begin
          abort_run("response seen with no accepted request");
        end
        cur = exp_q.pop_front();
        check_value("resp_hit", resp_hit, cur.hit);
        check_value("resp_rdata", resp_rdata, cur.rdata);
        // hits stay off the memory bus, everything else waits one cycle past the ack
        if (cur.write || !cur.hit) begin
          check_value("mem requests", mem_req_count, 1);
          check_value("mem_ack one cycle before resp_valid", ack_prev, 1);
        end else begin
          check_value("mem requests", mem_req_count, 0);
        end
        mem_req_count = 0;
        resp_count++;
      end
      // busy rises after acceptance and falls after the response
      if (resp_valid) begin
        busy_exp = 1'b0;
      end else if (req_valid && !busy_exp) begin
        busy_exp = 1'b1;
      end
    end
    ack_prev = mem_ack;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES));
    end
  end

endmodule

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := dcache_tb
FILELIST := project.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))
FAIL_MSG := Finished with errors
PASS_MSG := Finished with no errors

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* project.f */
rtl/brisc_pkg.sv
rtl/cache_pkg.sv
rtl/cache_line.sv
rtl/cache_array.sv
rtl/cache_ctrl.sv
rtl/dcache_top.sv
bench/dcache_assert.sv
bench/dcache_tb.sv
